// File: verilog/ooo_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Out-of-order station shared definitions
// Widths, tag count, transfer structs and tag-store states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ooo_pkg;

    // Tag space
    localparam int TAG_NUM = 8;
    localparam int TAG_W   = 3;
    localparam int CNT_W   = 4;

    // Payload and resource widths
    localparam int QUEUE_W = 4;
    localparam int CMD_W   = 16;
    localparam int RESP_W  = 16;
    localparam int DATA_W  = 32;

    // Request from the ingress thread
    typedef struct packed {
        logic [QUEUE_W-1:0] queue;
        logic [CMD_W-1:0]   cmd;
        logic [DATA_W-1:0]  data;
    } ingress_req_t;

    // Command to the resource manager, stamped with its tag
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [CMD_W-1:0] cmd;
    } resource_req_t;

    // Answer from the resource manager, any order
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [RESP_W-1:0] resp;
    } resource_resp_t;

    // Reorder buffer entry, one per tag
    typedef struct packed {
        logic [QUEUE_W-1:0] queue;
        logic [DATA_W-1:0]  data;
    } payload_t;

    // Joined result toward the egress thread
    typedef struct packed {
        logic [QUEUE_W-1:0] queue;
        logic [RESP_W-1:0]  resp;
        logic [DATA_W-1:0]  data;
    } egress_t;

    typedef enum logic {
        ST_FILL,
        ST_RUN
    } store_state_t;

endpackage

// File: verilog/ooo_issue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue stage that accepts ingress requests, claims a free
// tag and forwards the tagged command to the resource manager
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ooo_issue (
    input  logic                          i_clk,
    input  logic                          i_rst,

    input  logic                          i_ingress_valid,
    input  ooo_pkg::ingress_req_t         i_ingress,
    output logic                          o_ingress_ready,

    input  logic                          i_tag_avail,
    input  logic [ooo_pkg::TAG_W-1:0]     i_free_tag,
    output logic                          o_claim,
    output ooo_pkg::payload_t             o_claim_payload,

    output logic                          o_resource_req_valid,
    output ooo_pkg::resource_req_t        o_resource_req,
    input  logic                          i_resource_req_ready
);
    import ooo_pkg::*;

    logic req_accept;

    // Room when the output register is empty or draining this cycle
    assign o_ingress_ready = i_tag_avail && (!o_resource_req_valid || i_resource_req_ready);
    assign req_accept      = i_ingress_valid && o_ingress_ready;

    // Payload part goes into the reorder buffer under the claimed tag
    assign o_claim         = req_accept;
    assign o_claim_payload = '{queue: i_ingress.queue, data: i_ingress.data};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_resource_req_valid <= 1'b0;
        end else if (req_accept) begin
            o_resource_req_valid <= 1'b1;
        end else if (i_resource_req_ready) begin
            o_resource_req_valid <= 1'b0;
        end
    end

    // Command part leaves stamped with the tag
    always_ff @(posedge i_clk) begin
        if (req_accept) begin
            o_resource_req <= '{tag: i_free_tag, cmd: i_ingress.cmd};
        end
    end

    a_claim_needs_tag: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_claim |-> i_tag_avail
    );

endmodule

// File: verilog/ooo_tag_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag store: circular free list of tags, refilled after
// reset, plus the tag-indexed reorder buffer for payloads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ooo_tag_store (
    input  logic                          i_clk,
    input  logic                          i_rst,

    input  logic                          i_claim,
    input  ooo_pkg::payload_t             i_claim_payload,
    output logic                          o_tag_avail,
    output logic [ooo_pkg::TAG_W-1:0]     o_free_tag,

    input  logic                          i_release,
    input  logic [ooo_pkg::TAG_W-1:0]     i_release_tag,

    input  logic [ooo_pkg::TAG_W-1:0]     i_rd_tag,
    output ooo_pkg::payload_t             o_rd_payload,

    output logic [ooo_pkg::CNT_W-1:0]     o_free_tags
);
    import ooo_pkg::*;

    store_state_t     state;

    logic [TAG_W-1:0] tag_fifo [TAG_NUM];
    logic [TAG_W-1:0] rd_ptr;
    logic [TAG_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    payload_t         pay_mem [TAG_NUM];

    logic             fill_push;
    logic             push;
    logic             pop;
    logic [TAG_W-1:0] push_tag;

    // During fill the write pointer walks 0..TAG_NUM-1, so it is the tag itself
    assign fill_push = (state == ST_FILL);
    assign push      = fill_push || i_release;
    assign pop       = i_claim;
    assign push_tag  = fill_push ? wr_ptr : i_release_tag;

    assign o_free_tag  = tag_fifo[rd_ptr];
    assign o_tag_avail = (state == ST_RUN) && (count != '0);
    assign o_free_tags = count;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_FILL;
        end else if (state == ST_FILL && wr_ptr == TAG_W'(TAG_NUM - 1)) begin
            state <= ST_RUN;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + TAG_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + TAG_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            tag_fifo[wr_ptr] <= push_tag;
        end
    end

    // Reorder buffer, written at claim, read one cycle after the address
    always_ff @(posedge i_clk) begin
        if (i_claim) begin
            pay_mem[o_free_tag] <= i_claim_payload;
        end
        o_rd_payload <= pay_mem[i_rd_tag];
    end

    a_no_underflow: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_claim |-> (state == ST_RUN) && (count != '0)
    );

    a_count_bound: assert property (
        @(posedge i_clk) disable iff (i_rst)
        count <= CNT_W'(TAG_NUM)
    );

endmodule

// File: verilog/ooo_complete.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion: joins each resource answer with its stored
// payload in a two-stage pipeline and drives egress
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ooo_complete (
    input  logic                          i_clk,
    input  logic                          i_rst,

    input  logic                          i_resource_resp_valid,
    input  ooo_pkg::resource_resp_t       i_resource_resp,
    output logic                          o_resource_resp_ready,

    output logic [ooo_pkg::TAG_W-1:0]     o_rd_tag,
    input  ooo_pkg::payload_t             i_rd_payload,

    output logic                          o_release,
    output logic [ooo_pkg::TAG_W-1:0]     o_release_tag,

    output logic                          o_egress_valid,
    output ooo_pkg::egress_t              o_egress,
    input  logic                          i_egress_ready
);
    import ooo_pkg::*;

    // Stage 1 waits on the payload read
    logic             s1_valid;
    resource_resp_t   s1_resp;

    // Stage 2 tag rides along with the egress beat
    logic [TAG_W-1:0] s2_tag;

    logic             s1_ready;
    logic             s2_ready;
    logic             resp_accept;

    assign s2_ready              = !o_egress_valid || i_egress_ready;
    assign s1_ready              = !s1_valid || s2_ready;
    assign o_resource_resp_ready = s1_ready;
    assign resp_accept           = i_resource_resp_valid && o_resource_resp_ready;

    // Keep the address on the held tag so the read data stays put while stalled
    assign o_rd_tag = resp_accept ? i_resource_resp.tag : s1_resp.tag;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            s1_valid       <= 1'b0;
            o_egress_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= resp_accept;
            end
            if (s2_ready) begin
                o_egress_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (resp_accept) begin
            s1_resp <= i_resource_resp;
        end
        if (s1_valid && s2_ready) begin
            o_egress <= '{queue: i_rd_payload.queue,
                          resp:  s1_resp.resp,
                          data:  i_rd_payload.data};
            s2_tag   <= s1_resp.tag;
        end
    end

    // Tag goes back to the free list as the beat leaves
    assign o_release     = o_egress_valid && i_egress_ready;
    assign o_release_tag = s2_tag;

    a_egress_hold: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_egress_valid && !i_egress_ready |=> o_egress_valid && $stable(o_egress)
    );

endmodule

// File: verilog/ooo_station.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Out-of-order station top: issue, tag store, completion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ooo_station (
    input  logic                          i_clk,
    input  logic                          i_rst,

    input  logic                          i_ingress_valid,
    input  ooo_pkg::ingress_req_t         i_ingress,
    output logic                          o_ingress_ready,

    output logic                          o_resource_req_valid,
    output ooo_pkg::resource_req_t        o_resource_req,
    input  logic                          i_resource_req_ready,

    input  logic                          i_resource_resp_valid,
    input  ooo_pkg::resource_resp_t       i_resource_resp,
    output logic                          o_resource_resp_ready,

    output logic                          o_egress_valid,
    output ooo_pkg::egress_t              o_egress,
    input  logic                          i_egress_ready,

    output logic [ooo_pkg::CNT_W-1:0]     o_free_tags
);
    import ooo_pkg::*;

    // Issue side of the tag store
    logic             tag_avail;
    logic [TAG_W-1:0] free_tag;
    logic             claim;
    payload_t         claim_payload;

    // Completion side of the tag store
    logic [TAG_W-1:0] rd_tag;
    payload_t         rd_payload;
    logic             release_req;
    logic [TAG_W-1:0] release_tag;

    ooo_issue u_issue (
        .i_clk                (i_clk),
        .i_rst                (i_rst),
        .i_ingress_valid      (i_ingress_valid),
        .i_ingress            (i_ingress),
        .o_ingress_ready      (o_ingress_ready),
        .i_tag_avail          (tag_avail),
        .i_free_tag           (free_tag),
        .o_claim              (claim),
        .o_claim_payload      (claim_payload),
        .o_resource_req_valid (o_resource_req_valid),
        .o_resource_req       (o_resource_req),
        .i_resource_req_ready (i_resource_req_ready)
    );

    ooo_tag_store u_tag_store (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_claim         (claim),
        .i_claim_payload (claim_payload),
        .o_tag_avail     (tag_avail),
        .o_free_tag      (free_tag),
        .i_release       (release_req),
        .i_release_tag   (release_tag),
        .i_rd_tag        (rd_tag),
        .o_rd_payload    (rd_payload),
        .o_free_tags     (o_free_tags)
    );

    ooo_complete u_complete (
        .i_clk                 (i_clk),
        .i_rst                 (i_rst),
        .i_resource_resp_valid (i_resource_resp_valid),
        .i_resource_resp       (i_resource_resp),
        .o_resource_resp_ready (o_resource_resp_ready),
        .o_rd_tag              (rd_tag),
        .i_rd_payload          (rd_payload),
        .o_release             (release_req),
        .o_release_tag         (release_tag),
        .o_egress_valid        (o_egress_valid),
        .o_egress              (o_egress),
        .i_egress_ready        (i_egress_ready)
    );

endmodule

// File: test/ooo_station_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Out-of-order station testbench with stimulus, a resource
// responder, scoreboard assertions and a watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ooo_station_tb;
    import ooo_pkg::*;

    localparam int                CLK_PERIOD      = 10;
    localparam int                NUM_TESTS       = 6;
    localparam int                CYCLES_PER_TEST = 200;
    localparam logic [DATA_W-1:0] DATA_BASE       = 32'hA500_0000;

    logic             clk;
    logic             rst;
    logic             in_valid;
    ingress_req_t     in_req;
    logic             in_ready;
    logic             rq_valid;
    resource_req_t    rq;
    logic             rq_ready;
    logic             rs_valid;
    resource_resp_t   rs;
    logic             rs_ready;
    logic             eg_valid;
    egress_t          eg;
    logic             eg_ready;
    logic [CNT_W-1:0] free_tags;

    // Stimulus record by ingress index
    logic [QUEUE_W-1:0] rec_queue [256];
    logic [CMD_W-1:0]   rec_cmd [256];
    // Issued requests in issue order
    logic [TAG_W-1:0]   iss_tag [256];
    logic [CMD_W-1:0]   iss_cmd [256];
    // Ingress index behind each response in response order
    logic [7:0]         ord_idx [256];

    logic [7:0]         in_cnt;
    logic [7:0]         iss_cnt;
    logic [7:0]         rsp_cnt;
    logic [7:0]         eg_cnt;
    logic [7:0]         ord_head;
    logic [7:0]         ord_tail;
    logic [7:0]         next_idx;
    logic [7:0]         in_flight;
    logic [7:0]         lookup_idx;
    logic [TAG_NUM-1:0] tag_busy;
    egress_t            exp_by_data;
    logic [DATA_W-1:0]  exp_order_data;

    string test_name;
    logic  bp_mode;
    logic  filled;
    logic  drain_check;

    ooo_station uut (
        .i_clk                 (clk),
        .i_rst                 (rst),
        .i_ingress_valid       (in_valid),
        .i_ingress             (in_req),
        .o_ingress_ready       (in_ready),
        .o_resource_req_valid  (rq_valid),
        .o_resource_req        (rq),
        .i_resource_req_ready  (rq_ready),
        .i_resource_resp_valid (rs_valid),
        .i_resource_resp       (rs),
        .o_resource_resp_ready (rs_ready),
        .o_egress_valid        (eg_valid),
        .o_egress              (eg),
        .i_egress_ready        (eg_ready),
        .o_free_tags           (free_tags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired: the run did not finish in %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Test failed");
        $fatal(1);
    end

    // Ready on both output ports, random under back-pressure
    initial begin
        eg_ready = 1'b1;
        rq_ready = 1'b1;
        forever begin
            @(negedge clk);
            eg_ready = !bp_mode || (($urandom % 3) != 0);
            rq_ready = !bp_mode || (($urandom % 4) != 0);
        end
    end

    // Egress data word carries its ingress index in the low byte
    assign lookup_idx     = eg.data[7:0];
    assign exp_by_data    = '{queue: rec_queue[lookup_idx], resp: ~rec_cmd[lookup_idx],
                              data: DATA_BASE | 32'(lookup_idx)};
    assign exp_order_data = DATA_BASE | 32'(ord_idx[ord_head]);
    assign in_flight      = in_cnt - eg_cnt;

    always @(posedge clk) begin
        if (rst) begin
            in_cnt   <= '0;
            iss_cnt  <= '0;
            rsp_cnt  <= '0;
            eg_cnt   <= '0;
            ord_head <= '0;
            tag_busy <= '0;
        end else begin
            if (in_valid && in_ready) begin
                in_cnt <= in_cnt + 8'd1;
            end
            if (rq_valid && rq_ready) begin
                iss_tag[iss_cnt]  <= rq.tag;
                iss_cmd[iss_cnt]  <= rq.cmd;
                iss_cnt           <= iss_cnt + 8'd1;
                tag_busy[rq.tag]  <= 1'b1;
            end
            if (rs_valid && rs_ready) begin
                rsp_cnt <= rsp_cnt + 8'd1;
            end
            if (eg_valid && eg_ready) begin
                eg_cnt                       <= eg_cnt + 8'd1;
                ord_head                     <= ord_head + 8'd1;
                tag_busy[iss_tag[lookup_idx]] <= 1'b0;
            end
        end
    end

    task automatic fail_value(input string what, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
        $display("Error: %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
        $display("Test failed");
        $fatal(1);
    endtask

    a_reset_quiet: assert property (@(posedge clk) rst |=> !in_ready && !rq_valid && !eg_valid)
        else fail_value("outputs after reset", 64'd0, 64'({in_ready, rq_valid, eg_valid}));

    a_free_count: assert property (@(posedge clk) disable iff (rst || !filled)
        8'(free_tags) == 8'(TAG_NUM) - in_flight)
        else fail_value("free tags", 64'(8'(TAG_NUM) - in_flight), 64'(free_tags));

    a_full_stall: assert property (@(posedge clk) disable iff (rst)
        in_flight == 8'(TAG_NUM) |-> !in_ready)
        else fail_value("ingress ready with all tags out", 64'd0, 64'(in_ready));

    a_tag_unique: assert property (@(posedge clk) disable iff (rst)
        rq_valid && rq_ready |-> !tag_busy[rq.tag])
        else fail_value("tag already in flight", 64'd0, 64'(tag_busy[rq.tag]));

    a_req_cmd: assert property (@(posedge clk) disable iff (rst)
        rq_valid && rq_ready |-> rq.cmd == rec_cmd[iss_cnt])
        else fail_value("resource command", 64'(rec_cmd[iss_cnt]), 64'(rq.cmd));

    a_egress_order: assert property (@(posedge clk) disable iff (rst)
        eg_valid && eg_ready |-> ord_head != ord_tail && eg.data == exp_order_data)
        else fail_value("egress data word", 64'(exp_order_data), 64'(eg.data));

    a_egress_fields: assert property (@(posedge clk) disable iff (rst)
        eg_valid && eg_ready |-> eg == exp_by_data)
        else fail_value("egress beat", {12'd0, exp_by_data}, {12'd0, eg});

    a_egress_stable: assert property (@(posedge clk) disable iff (rst)
        eg_valid && !eg_ready |=> eg_valid && $stable(eg))
        else fail_value("held egress beat", {12'd0, $past(eg)}, {12'd0, eg});

    a_drained: assert property (@(posedge clk) disable iff (rst)
        drain_check |-> eg_cnt == in_cnt && free_tags == CNT_W'(TAG_NUM))
        else fail_value("egress count and free tags", {in_cnt, 8'(TAG_NUM)},
                        {eg_cnt, 8'(free_tags)});

    task automatic drive_request();
        in_req = '{queue: QUEUE_W'($urandom), cmd: CMD_W'($urandom),
                   data: DATA_BASE | 32'(next_idx)};
        rec_queue[next_idx] = in_req.queue;
        rec_cmd[next_idx]   = in_req.cmd;
        in_valid            = 1'b1;
    endtask

    task automatic send_requests(input int n);
        logic [7:0] start_cnt;
        for (int i = 0; i < n; i++) begin
            drive_request();
            start_cnt = in_cnt;
            @(negedge clk);
            while (in_cnt == start_cnt) @(negedge clk);
            next_idx = next_idx + 8'd1;
        end
        in_valid = 1'b0;
    endtask

    // Responder answers a batch in reverse or shuffled order
    task automatic answer_batch(input int first, input int n, input bit shuffle);
        int         order [TAG_NUM];
        int         j;
        int         tmp;
        logic [7:0] k;
        logic [7:0] start_cnt;
        for (int i = 0; i < n; i++) begin
            order[i] = shuffle ? first + i : first + n - 1 - i;
        end
        for (int i = n - 1; shuffle && i > 0; i--) begin
            j        = int'($urandom_range(i, 0));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < n; i++) begin
            k                 = 8'(order[i]);
            rs                = '{tag: iss_tag[k], resp: ~iss_cmd[k]};
            rs_valid          = 1'b1;
            ord_idx[ord_tail] = k;
            ord_tail          = ord_tail + 8'd1;
            start_cnt         = rsp_cnt;
            @(negedge clk);
            while (rsp_cnt == start_cnt) @(negedge clk);
        end
        rs_valid = 1'b0;
    endtask

    task automatic drain();
        while (iss_cnt != next_idx || ord_head != ord_tail) @(negedge clk);
        drain_check = 1'b1;
        @(negedge clk);
        drain_check = 1'b0;
    endtask

    task automatic run_batch(input int n, input bit shuffle);
        int first;
        first = int'(next_idx);
        send_requests(n);
        while (iss_cnt != next_idx) @(negedge clk);
        answer_batch(first, n, shuffle);
        drain();
    endtask

    initial begin
        void'($urandom(51060));
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_req      = '0;
        rs_valid    = 1'b0;
        rs          = '0;
        bp_mode     = 1'b0;
        filled      = 1'b0;
        drain_check = 1'b0;
        next_idx    = '0;
        ord_tail    = '0;
        test_name   = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (free_tags != CNT_W'(TAG_NUM)) @(negedge clk);
        filled = 1'b1;

        // Ninth request must stall while the responder is idle
        test_name = "exhaustion";
        send_requests(TAG_NUM);
        drive_request();
        repeat (20) @(negedge clk);
        in_valid = 1'b0;
        while (iss_cnt != next_idx) @(negedge clk);
        test_name = "reverse";
        answer_batch(0, TAG_NUM, 1'b0);
        drain();

        test_name = "random";
        run_batch(TAG_NUM, 1'b1);

        test_name = "backpressure";
        bp_mode   = 1'b1;
        run_batch(TAG_NUM, 1'b1);

        test_name = "recycle";
        run_batch(8, 1'b1);
        run_batch(8, 1'b1);
        run_batch(4, 1'b1);
        bp_mode = 1'b0;

        $display("Test passed");
        $finish;
    end

endmodule

// File: list.f
verilog/ooo_pkg.sv
verilog/ooo_issue.sv
verilog/ooo_tag_store.sv
verilog/ooo_complete.sv
verilog/ooo_station.sv
test/ooo_station_tb.sv

// File: run.sh
#!/bin/sh
# Build the out-of-order station testbench with Verilator and run it.
# The run passes only when the simulation prints the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module ooo_station_tb -f list.f -o ooo_sim \
    && ./obj_dir/ooo_sim | tee /dev/stderr | grep -q "^Test passed$" \
    && echo "Simulation run: PASS" \
    || { echo "Simulation run: FAIL"; exit 1; }
